// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_mem_subsys \
	-Mdir obj_dir -o tb_sim

out="$(./obj_dir/tb_sim)"
echo "$out"
echo "$out" | grep -qx "TB PASSED"

// ==== source/line_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_cache
	import mem_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	cache_access_if.store acc
);

	logic [DATA_W-1:0] data_mem [LINES];
	logic [TAG_W-1:0]  tag_mem  [LINES];
	logic [LINES-1:0]  valid;
	logic [LINES-1:0]  dirty;

	logic [INDEX_W-1:0] idx;
	logic [TAG_W-1:0]   tag;
	mem_addr_u          victim;

	assign idx = acc.addr.split.index;
	assign tag = acc.addr.split.tag;

	////////////////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////////////////

	assign acc.hit     = valid[idx] && (tag_mem[idx] == tag);
	assign acc.rd_data = data_mem[idx];

	// An invalid line never needs write-back
	assign acc.victim_dirty = valid[idx] & dirty[idx];

	always_comb begin
		victim.split.tag   = tag_mem[idx];
		victim.split.index = idx;
	end

	assign acc.victim_addr = victim;

	////////////////////////////////////////////////////////////////////////
	// Update
	////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (acc.wr_en) begin
			data_mem[idx] <= acc.wr_data;
			tag_mem[idx]  <= tag;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			valid <= '0;
			dirty <= '0;
		end else if (acc.wr_en) begin
			valid[idx] <= 1'b1;
			dirty[idx] <= acc.dirty_set;
		end
	end

endmodule

`default_nettype wire

// ==== source/mem_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Request port, level request held until a one-cycle done
////////////////////////////////////////////////////////////////////////////

interface mem_port_if
	import mem_pkg::*;
();
	logic              req;
	logic              wr;
	mem_addr_u         addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;
	logic              done;

	modport requester (
		output req, wr, addr, wdata,
		input  rdata, done
	);

	modport server (
		input  req, wr, addr, wdata,
		output rdata, done
	);

	// Read-only port, no write strobe or write data
	modport fetch_server (
		input  req, addr,
		output rdata, done
	);
endinterface

////////////////////////////////////////////////////////////////////////////
// Cache lookup and update between controller and line storage
////////////////////////////////////////////////////////////////////////////

interface cache_access_if
	import mem_pkg::*;
();
	mem_addr_u         addr;
	logic              wr_en;
	logic [DATA_W-1:0] wr_data;
	logic              dirty_set;
	logic              hit;
	logic [DATA_W-1:0] rd_data;
	logic              victim_dirty;
	mem_addr_u         victim_addr;

	modport ctrl (
		output addr, wr_en, wr_data, dirty_set,
		input  hit, rd_data, victim_dirty, victim_addr
	);

	modport store (
		input  addr, wr_en, wr_data, dirty_set,
		output hit, rd_data, victim_dirty, victim_addr
	);
endinterface

`default_nettype wire

// ==== source/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// Address and data geometry
	localparam int ADDR_W  = 16;
	localparam int DATA_W  = 16;
	localparam int INDEX_W = 6;
	localparam int TAG_W   = ADDR_W - INDEX_W;
	localparam int LINES   = 1 << INDEX_W;

	// Controller state codes
	localparam logic [2:0] ST_IDLE       = 3'd0;
	localparam logic [2:0] ST_WB_SETUP   = 3'd1;
	localparam logic [2:0] ST_WB_STROBE  = 3'd2;
	localparam logic [2:0] ST_RD_STROBE  = 3'd3;
	localparam logic [2:0] ST_RD_CAPTURE = 3'd4;
	localparam logic [2:0] ST_FILL       = 3'd5;
	localparam logic [2:0] ST_RESPOND    = 3'd6;

	typedef struct packed {
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] index;
	} addr_split_t;

	// Same word seen flat by the ports and SRAM, split by the cache
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		addr_split_t       split;
	} mem_addr_u;

endpackage

`default_nettype wire

// ==== source/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top
	import mem_pkg::*;
(
	input  wire logic              clk,
	input  wire logic              rst,

	input  wire logic              fetch_req,
	input  wire logic [ADDR_W-1:0] fetch_addr,
	output logic [DATA_W-1:0]      fetch_rdata,
	output logic                   fetch_done,

	input  wire logic              exe_req,
	input  wire logic              exe_wr,
	input  wire logic [ADDR_W-1:0] exe_addr,
	input  wire logic [DATA_W-1:0] exe_wdata,
	output logic [DATA_W-1:0]      exe_rdata,
	output logic                   exe_done,

	output logic [ADDR_W-1:0]      sram_addr,
	output logic [DATA_W-1:0]      sram_wdata,
	input  wire logic [DATA_W-1:0] sram_rdata,
	output logic                   sram_en_n,
	output logic                   sram_oe_n,
	output logic                   sram_we_n
);

	mem_port_if     fetch_if ();
	mem_port_if     exe_if ();
	mem_port_if     ctrl_if ();
	cache_access_if cache_if ();

	// Fetch side carries no write fields
	assign fetch_if.req  = fetch_req;
	assign fetch_if.addr = fetch_addr;
	assign fetch_rdata   = fetch_if.rdata;
	assign fetch_done    = fetch_if.done;

	assign exe_if.req   = exe_req;
	assign exe_if.wr    = exe_wr;
	assign exe_if.addr  = exe_addr;
	assign exe_if.wdata = exe_wdata;
	assign exe_rdata    = exe_if.rdata;
	assign exe_done     = exe_if.done;

	port_arbiter port_arbiter_inst (
		.clk   (clk),
		.rst   (rst),
		.fetch (fetch_if.fetch_server),
		.exe   (exe_if.server),
		.down  (ctrl_if.requester)
	);

	line_cache line_cache_inst (
		.clk (clk),
		.rst (rst),
		.acc (cache_if.store)
	);

	sram_ctrl sram_ctrl_inst (
		.clk        (clk),
		.rst        (rst),
		.up         (ctrl_if.server),
		.cache      (cache_if.ctrl),
		.sram_addr  (sram_addr),
		.sram_wdata (sram_wdata),
		.sram_rdata (sram_rdata),
		.sram_en_n  (sram_en_n),
		.sram_oe_n  (sram_oe_n),
		.sram_we_n  (sram_we_n)
	);

endmodule

`default_nettype wire

// ==== source/port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_arbiter
	import mem_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst,
	mem_port_if.fetch_server fetch,
	mem_port_if.server       exe,
	mem_port_if.requester    down
);

	logic locked;
	logic grant_exe_q;
	logic sel_exe;

	// Execute wins when free, otherwise hold whoever started
	assign sel_exe = locked ? grant_exe_q : exe.req;

	////////////////////////////////////////////////////////////////////////
	// Request mux, passes straight through
	////////////////////////////////////////////////////////////////////////

	assign down.req   = sel_exe ? exe.req : fetch.req;
	assign down.wr    = sel_exe & exe.wr;
	assign down.addr  = sel_exe ? exe.addr : fetch.addr;
	assign down.wdata = sel_exe ? exe.wdata : '0;

	// Responses only reach the granted side
	assign exe.done    = down.done & sel_exe;
	assign exe.rdata   = sel_exe ? down.rdata : '0;
	assign fetch.done  = down.done & ~sel_exe;
	assign fetch.rdata = sel_exe ? '0 : down.rdata;

	always_ff @(posedge clk) begin
		if (!rst) begin
			locked      <= 1'b0;
			grant_exe_q <= 1'b0;
		end else if (locked) begin
			if (down.done)
				locked <= 1'b0;
		end else if (down.req) begin
			locked      <= 1'b1;
			grant_exe_q <= sel_exe;
		end
	end

	a_fetch_done_held: assert property (@(posedge clk) disable iff (!rst)
		fetch.done |-> fetch.req);

	a_exe_done_held: assert property (@(posedge clk) disable iff (!rst)
		exe.done |-> exe.req);

endmodule

`default_nettype wire

// ==== source/sram_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl
	import mem_pkg::*;
(
	input  wire logic               clk,
	input  wire logic               rst,
	mem_port_if.server              up,
	cache_access_if.ctrl            cache,
	output logic [ADDR_W-1:0]       sram_addr,
	output logic [DATA_W-1:0]       sram_wdata,
	input  wire logic [DATA_W-1:0]  sram_rdata,
	output logic                    sram_en_n,
	output logic                    sram_oe_n,
	output logic                    sram_we_n
);

	logic [2:0]        state;
	logic [2:0]        state_next;
	logic [DATA_W-1:0] fill_word;
	logic [DATA_W-1:0] resp_data;
	logic              need_wb;
	logic              start;

	// A hit never evicts, even when the line is dirty
	assign need_wb = cache.victim_dirty & ~cache.hit;
	assign start   = (state == ST_IDLE) & up.req;

	////////////////////////////////////////////////////////////////////////
	// State sequence
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (up.req) begin
					if (need_wb)
						state_next = ST_WB_SETUP;
					else if (up.wr)
						state_next = ST_FILL;
					else if (cache.hit)
						state_next = ST_RESPOND;
					else
						state_next = ST_RD_STROBE;
				end
			end
			ST_WB_SETUP:   state_next = ST_WB_STROBE;
			ST_WB_STROBE:  state_next = up.wr ? ST_FILL : ST_RD_STROBE;
			ST_RD_STROBE:  state_next = ST_RD_CAPTURE;
			ST_RD_CAPTURE: state_next = ST_FILL;
			ST_FILL:       state_next = ST_RESPOND;
			ST_RESPOND:    state_next = ST_IDLE;
			default:       state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	// Sampled while OE is still low so the address is stable
	always_ff @(posedge clk) begin
		if (state == ST_RD_STROBE)
			fill_word <= sram_rdata;
	end

	always_ff @(posedge clk) begin
		if (start && up.wr)
			resp_data <= up.wdata;
		else if (start && cache.hit)
			resp_data <= cache.rd_data;
		else if (state == ST_RD_CAPTURE)
			resp_data <= fill_word;
	end

	////////////////////////////////////////////////////////////////////////
	// Cache side, request operands are held until done
	////////////////////////////////////////////////////////////////////////

	assign cache.addr      = up.addr;
	assign cache.wr_en     = (state == ST_FILL);
	assign cache.wr_data   = up.wr ? up.wdata : fill_word;
	assign cache.dirty_set = up.wr;  // refills come in clean

	assign up.done  = (state == ST_RESPOND);
	assign up.rdata = resp_data;

	////////////////////////////////////////////////////////////////////////
	// SRAM pins
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		if (state == ST_WB_SETUP || state == ST_WB_STROBE)
			sram_addr = cache.victim_addr.flat;
		else
			sram_addr = up.addr.flat;
	end

	// Victim word sits in the indexed line until the fill
	assign sram_wdata = cache.rd_data;
	assign sram_en_n  = (state == ST_IDLE);
	assign sram_oe_n  = (state != ST_RD_STROBE);
	assign sram_we_n  = (state != ST_WB_STROBE);

	a_strobe_excl: assert property (@(posedge clk) disable iff (!rst)
		!(!sram_oe_n && !sram_we_n));

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
		up.done |=> !up.done);

endmodule

`default_nettype wire

// ==== verif/sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_model
	import mem_pkg::*;
(
	input  wire logic [ADDR_W-1:0] sram_addr,
	input  wire logic [DATA_W-1:0] sram_wdata,
	output logic [DATA_W-1:0]      sram_rdata,
	input  wire logic              sram_en_n,
	input  wire logic              sram_oe_n,
	input  wire logic              sram_we_n
);

	logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

	// Read path is open only while chip and output enable are low
	assign sram_rdata = (!sram_en_n && !sram_oe_n) ? mem[sram_addr] : '0;

	// Address and data settle a cycle before the strobe falls
	always @(negedge sram_we_n) begin
		if (!sram_en_n)
			mem[sram_addr] = sram_wdata;
	end

	task automatic load_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		mem[addr] = data;
	endtask

	task automatic peek_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		data = mem[addr];
	endtask

endmodule

`default_nettype wire

// ==== verif/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys
	import mem_pkg::*;
();
	localparam int LAT_SOLO    = 6;
	localparam int LAT_SHARED  = 2 * LAT_SOLO + 2;
	localparam int MISS_COUNT  = 20;
	localparam int RAND_CYCLES = 300;
	// A random requester needs at least three cycles per request
	localparam int REQ_TOTAL   = 2 * MISS_COUNT + 8 + 2 * (RAND_CYCLES / 3);
	localparam int CYCLE_LIMIT = REQ_TOTAL * LAT_SOLO + 200;
	localparam int P_IDLE = 0, P_BUSY = 1, P_HOLD = 2, P_GAP = 3;

	logic              clk, rst;
	logic              fetch_req, fetch_done, exe_req, exe_wr, exe_done;
	logic [ADDR_W-1:0] fetch_addr, exe_addr, sram_addr;
	logic [DATA_W-1:0] fetch_rdata, exe_wdata, exe_rdata, sram_wdata, sram_rdata;
	logic              sram_en_n, sram_oe_n, sram_we_n;
	logic [DATA_W-1:0] ref_mem [0:(1<<ADDR_W)-1];
	integer            seed;
	int                cycles, errors, checks, test_base, lat_limit;
	int                f_state, e_state, f_lat, e_lat, f_done_cyc, e_done_cyc;

	mem_subsys_top mem_subsys_top_inst (.*);
	sram_model     sram_model_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin : watchdog
		int count;
		count = 0;
		while (count < CYCLE_LIMIT) begin
			@(posedge clk);
			count++;
		end
		$display("run timed out after %0d cycles", CYCLE_LIMIT);
		$display("TB FAILED");
		$finish;
	end

	task automatic check_value(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic check_quiet();
		check_value("fetch_done", 16'(fetch_done), 16'h0);
		check_value("exe_done", 16'(exe_done), 16'h0);
		check_value("{sram_en_n,sram_oe_n,sram_we_n}",
			16'({sram_en_n, sram_oe_n, sram_we_n}), 16'h7);
	endtask

	// Write-back carries the latest written word, a refill reads a word not in the cache
	task automatic check_sram_bus();
		if (!sram_oe_n || !sram_we_n)
			check_value("sram_en_n", 16'(sram_en_n), 16'h0);
		if (!sram_we_n)
			check_value("sram_wdata", sram_wdata, ref_mem[sram_addr]);
		if (!sram_oe_n)
			check_value("sram_rdata", sram_rdata, ref_mem[sram_addr]);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Requesters, advanced once per falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic tick();
		@(negedge clk);
		cycles++;
		if (rst)
			check_sram_bus();
		if (fetch_done && f_state != P_BUSY) begin
			errors++;
			$display("fetch_done pulsed with no fetch request pending");
		end
		if (exe_done && e_state != P_BUSY) begin
			errors++;
			$display("exe_done pulsed with no execute request pending");
		end
		// Hold through the done cycle, drop, then one quiet cycle
		if (f_state == P_HOLD) begin
			fetch_req = 1'b0;
			f_state   = P_GAP;
		end else if (f_state == P_GAP) begin
			f_state = P_IDLE;
		end else if (f_state == P_BUSY) begin
			f_lat++;
			if (fetch_done) begin
				check_value("fetch_rdata", fetch_rdata, ref_mem[fetch_addr]);
				f_done_cyc = cycles;
				f_state    = P_HOLD;
			end else if (f_lat == lat_limit) begin
				errors++;
				$display("fetch request saw no done within %0d cycles", lat_limit);
			end
		end
		if (e_state == P_HOLD) begin
			exe_req = 1'b0;
			e_state = P_GAP;
		end else if (e_state == P_GAP) begin
			e_state = P_IDLE;
		end else if (e_state == P_BUSY) begin
			e_lat++;
			if (exe_done) begin
				if (exe_wr)
					ref_mem[exe_addr] = exe_wdata;
				else
					check_value("exe_rdata", exe_rdata, ref_mem[exe_addr]);
				e_done_cyc = cycles;
				e_state    = P_HOLD;
			end else if (e_lat == lat_limit) begin
				errors++;
				$display("execute request saw no done within %0d cycles", lat_limit);
			end
		end
	endtask

	task automatic start_fetch(input logic [ADDR_W-1:0] addr);
		fetch_req  = 1'b1;
		fetch_addr = addr;
		f_lat      = 0;
		f_state    = P_BUSY;
	endtask

	task automatic start_exe(input logic wr, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata);
		exe_req   = 1'b1;
		exe_wr    = wr;
		exe_addr  = addr;
		exe_wdata = wdata;
		e_lat     = 0;
		e_state   = P_BUSY;
	endtask

	task automatic wait_idle();
		while (f_state != P_IDLE || e_state != P_IDLE)
			tick();
	endtask

	task automatic end_test(input string name);
		$display("test %s finished with %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	initial begin
		logic [31:0]       r;
		logic [ADDR_W-1:0] a, b;
		logic [DATA_W-1:0] w, v;

		seed      = 82;
		cycles    = 0;
		errors    = 0;
		checks    = 0;
		test_base = 0;
		f_state   = P_IDLE;
		e_state   = P_IDLE;
		lat_limit = LAT_SOLO;
		{rst, fetch_req, exe_req, exe_wr} = '0;
		{fetch_addr, exe_addr, exe_wdata} = '0;

		// Random preload, mirrored into the reference array
		a = '0;
		do begin
			w = 16'($random(seed));
			ref_mem[a] = w;
			sram_model_inst.load_word(a, w);
			a++;
		end while (a != '0);

		repeat (16) begin
			tick();
			check_quiet();
		end
		rst = 1'b1;
		repeat (3) begin
			tick();
			check_quiet();
		end
		end_test("reset_state");

		for (int i = 0; i < MISS_COUNT; i++) begin
			start_fetch(16'($random(seed)));
			wait_idle();
		end
		for (int i = 0; i < MISS_COUNT; i++) begin
			start_exe(1'b0, 16'($random(seed)), '0);
			wait_idle();
		end
		end_test("read_misses");

		r = $random(seed);
		start_exe(1'b1, r[15:0], r[31:16]);
		wait_idle();
		start_exe(1'b0, r[15:0], '0);
		wait_idle();
		check_value("exe_latency", 16'(e_lat), 16'd1);
		start_fetch(r[15:0]);
		wait_idle();
		check_value("fetch_latency", 16'(f_lat), 16'd1);
		end_test("write_read_hit");

		// Flipping the top tag bit keeps the index
		r = $random(seed);
		a = r[15:0];
		b = a ^ 16'h8000;
		v = r[31:16];
		start_exe(1'b1, a, v);
		wait_idle();
		start_exe(1'b1, b, ~v);
		wait_idle();
		sram_model_inst.peek_word(a, w);
		check_value("sram_mem_a", w, v);
		start_exe(1'b0, a, '0);
		wait_idle();
		check_value("exe_latency", 16'(e_lat), 16'(LAT_SOLO));
		end_test("dirty_eviction");

		lat_limit = LAT_SHARED;
		r = $random(seed);
		start_fetch(r[15:0]);
		start_exe(1'b0, r[31:16], '0);
		wait_idle();
		if (e_done_cyc >= f_done_cyc) begin
			errors++;
			$display("fetch_done arrived before exe_done");
		end
		end_test("arbitration");

		// Four indices with four tags each, so lines keep colliding
		repeat (RAND_CYCLES) begin
			tick();
			r = $random(seed);
			if (f_state == P_IDLE && r[4])
				start_fetch({8'd0, r[3:2], 4'd0, r[1:0]});
			r = $random(seed);
			if (e_state == P_IDLE && r[4])
				start_exe(r[5], {8'd0, r[3:2], 4'd0, r[1:0]}, r[31:16]);
		end
		wait_idle();
		end_test("random_traffic");

		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/mem_pkg.sv
source/mem_ifs.sv
source/port_arbiter.sv
source/line_cache.sv
source/sram_ctrl.sv
source/mem_subsys_top.sv
verif/sram_model.sv
verif/tb_mem_subsys.sv
